// ==== project.f ====
+incdir+include
verilog/board_status_pkg.sv
verilog/board_pad_pkg.sv
verilog/debug_status_if.sv
verilog/glitch_filter.sv
verilog/board_status_gen.sv
verilog/i2c_pad_ctrl.sv
verilog/gpio_debug_mux.sv
verilog/board_io_top.sv
tb/board_io_chk.sv
tb/tb_board_io.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the board IO testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f project.f --top-module tb_board_io -o sim_board_io
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/sim_board_io 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qxF '** PASS **'; then
  exit 0
fi
exit 1

// ==== tb/tb_board_io.sv ====
// Fixed waits assume 2 sync stages and a registered mux; user GPIO values come from seeded $random
`default_nettype none

`include "board_defs.svh"

module tb_board_io;
  timeunit 1ns;
  timeprecision 100ps;

  import board_pad_pkg::*;
  import board_status_pkg::*;

  localparam int ROWS     = 8;
  localparam int PAD_WAIT = 2 + `GLITCH_DEPTH + 2;  // Sync, filter depth, margin

  // ------------------------------
  // Stimulus table
  // ------------------------------

  // Mux enables, then {synth, pll, vsync} levels, one entry per row
  localparam logic [7:0] ROW_EN [ROWS] = '{8'h00, 8'h07, 8'h04, 8'hf0,
                                           8'h5a, 8'ha2, 8'hff, 8'h08};
  localparam logic [2:0] ROW_ST [ROWS] = '{3'b111, 3'b101, 3'b010, 3'b001,
                                           3'b000, 3'b011, 3'b111, 3'b110};

  gpio_vec_t     tbl_user [ROWS];      // Random user values
  cam_gpio_vec_t tbl_cam_user [ROWS];
  gpio_vec_t     tbl_exp [ROWS];       // Expected pins after 3 cycles
  cam_gpio_vec_t tbl_cam_exp [ROWS];

  logic          hif_clk = 1'b0;
  logic          hif_rst = 1'b1;
  logic          i_pps = 1'b0;
  logic          i_synth_locked = 1'b0;
  logic          i_sensor_pll_locked = 1'b0;
  logic          i_vsync = 1'b0;
  gpio_mux_en_t  i_mux_en = '0;
  gpio_vec_t     i_gpio_out = '1;      // All ones while in reset
  cam_gpio_vec_t i_cam_gpio_out = '1;
  i2c_line_vec_t i_scl_pad = '1;       // Bus idles high
  i2c_line_vec_t i_sda_pad = '1;
  i2c_line_vec_t i_scl_en = '0;
  i2c_line_vec_t i_sda_en = '0;
  gpio_vec_t     o_gpio;
  cam_gpio_vec_t o_cam_gpio;
  i2c_line_vec_t o_scl_drive_low;
  i2c_line_vec_t o_sda_drive_low;
  i2c_line_vec_t o_scl;
  i2c_line_vec_t o_sda;

  integer seed = 32'h5d70_f57f;
  int     checks = 0;
  int     errors = 0;
  int     timeouts = 0;

  always #10 hif_clk = ~hif_clk;  // 20 ns period

  board_io_top dut0 (.*);

  // Pins taken over by status, per the enable layout
  function automatic gpio_vec_t gpio_mask(input logic [7:0] en);
    return {en[0], en[1], en[2], en[2], 12'h000};
  endfunction

  function automatic cam_gpio_vec_t cam_mask(input logic [7:0] en);
    cam_gpio_vec_t m;
    m    = '0;
    m[3] = en[4];
    m[6] = en[5];
    m[7] = en[6];
    m[8] = en[7];
    return m;
  endfunction

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic build_table();
    gpio_vec_t     lvl;
    cam_gpio_vec_t cam_lvl;
    for (int k = 0; k < ROWS; k++) begin
      tbl_user[k]     = gpio_vec_t'($random(seed));
      tbl_cam_user[k] = cam_gpio_vec_t'($random(seed));
      lvl             = {1'b0, ROW_ST[k][0], ROW_ST[k][2], ROW_ST[k][1], 12'h000};  // PPS idle
      cam_lvl         = {`CAM_GPIO_WIDTH{ROW_ST[k][0]}};
      tbl_exp[k]      = (tbl_user[k] & ~gpio_mask(ROW_EN[k])) | (lvl & gpio_mask(ROW_EN[k]));
      tbl_cam_exp[k]  = (tbl_cam_user[k] & ~cam_mask(ROW_EN[k])) | (cam_lvl & cam_mask(ROW_EN[k]));
    end
  endtask

  // ------------------------------
  // Bounded waits
  // ------------------------------

  task automatic wait_pps_pin(input int limit);
    int n;
    n = 0;
    while (o_gpio[15] !== 1'b1 && n < limit) begin
      @(negedge hif_clk);
      n++;
    end
    if (o_gpio[15] !== 1'b1) begin
      $display("Timeout: GPIO 15 stayed low %0d cycles after the PPS pulse", limit);
      timeouts++;
    end
  endtask

  task automatic wait_sda_low(input int port, input int limit, output int waited);
    waited = 0;
    while (o_sda[port] !== 1'b0 && waited < limit) begin
      @(negedge hif_clk);
      waited++;
    end
    if (o_sda[port] !== 1'b0) begin
      $display("Timeout: SDA %0d readback still high %0d cycles after the pad fell", port, limit);
      timeouts++;
    end
  endtask

  // ------------------------------
  // Test steps
  // ------------------------------

  task automatic reset_and_check();
    repeat (16) @(posedge hif_clk);
    @(negedge hif_clk);
    hif_rst = 1'b0;
    check_value("o_gpio after reset", 32'(o_gpio), 32'd0);
    check_value("o_cam_gpio after reset", 32'(o_cam_gpio), 32'd0);
    check_value("PPS stretch after reset", 32'(dut0.u_status_gen.pps_stretch), 32'd0);
    check_value("o_scl with enables low", 32'(o_scl), 32'd0);
    check_value("o_sda with enables low", 32'(o_sda), 32'd0);
  endtask

  task automatic run_mux_table();
    gpio_vec_t     keep;
    cam_gpio_vec_t cam_keep;
    for (int k = 0; k < ROWS; k++) begin
      i_mux_en       = gpio_mux_en_t'(ROW_EN[k]);
      i_gpio_out     = tbl_user[k];
      i_cam_gpio_out = tbl_cam_user[k];
      {i_synth_locked, i_sensor_pll_locked, i_vsync} = ROW_ST[k];
      keep     = ~gpio_mask(ROW_EN[k]);
      cam_keep = ~cam_mask(ROW_EN[k]);
      @(negedge hif_clk);                        // User bits after 1 cycle
      check_value("gpio user bits", 32'(o_gpio & keep), 32'(tbl_user[k] & keep));
      check_value("cam gpio user bits", 32'(o_cam_gpio & cam_keep),
                  32'(tbl_cam_user[k] & cam_keep));
      repeat (2) @(negedge hif_clk);             // Status bits after 3 cycles
      check_value("o_gpio", 32'(o_gpio), 32'(tbl_exp[k]));
      check_value("o_cam_gpio", 32'(o_cam_gpio), 32'(tbl_cam_exp[k]));
    end
  endtask

  task automatic run_pps_stretch();
    int len;
    i_mux_en = gpio_mux_en_t'(8'h01);            // pps_en only
    repeat (3) @(negedge hif_clk);
    i_pps = 1'b1;
    @(negedge hif_clk);
    i_pps = 1'b0;
    wait_pps_pin(4);
    if (timeouts != 0) return;
    len = 0;
    while (o_gpio[15] === 1'b1 && len < 20) begin
      len++;
      @(negedge hif_clk);
    end
    check_value("PPS stretch cycles on GPIO 15", len, 32'd9);
  endtask

  task automatic run_i2c();
    i2c_line_vec_t en_rand;
    i2c_line_vec_t exp_low;
    int            waited;
    for (int k = 0; k < 4; k++) begin
      en_rand  = i2c_line_vec_t'($random(seed));
      i_scl_en = en_rand;
      i_sda_en = ~en_rand;
      #1;                                        // Combinational drive
      exp_low = ~en_rand;
      check_value("o_scl_drive_low", 32'(o_scl_drive_low), 32'(exp_low));
      check_value("o_sda_drive_low", 32'(o_sda_drive_low), 32'(en_rand));
      @(negedge hif_clk);
    end
    i_scl_en = '1;
    i_sda_en = '1;
    @(negedge hif_clk);
    check_value("o_scl idle", 32'(o_scl), 32'hf);
    check_value("o_sda idle", 32'(o_sda), 32'hf);
    i_scl_pad[1] = 1'b0;                         // Short glitch
    repeat (3) @(negedge hif_clk);
    i_scl_pad[1] = 1'b1;
    repeat (PAD_WAIT) begin
      check_value("SCL 1 after a 3-cycle glitch", 32'(o_scl), 32'hf);
      @(negedge hif_clk);
    end
    i_sda_pad[0] = 1'b0;                         // Held low for 20 cycles
    wait_sda_low(0, PAD_WAIT, waited);
    if (timeouts != 0) return;
    check_value("o_sda after a held low", 32'(o_sda), 32'he);
    repeat (20 - waited) @(negedge hif_clk);
    i_sda_pad[0] = 1'b1;
    i_sda_en[2]  = 1'b0;
    #1;
    check_value("SDA 2 readback while disabled", 32'(o_sda[2]), 32'd0);
    check_value("SDA 2 drive low while disabled", 32'(o_sda_drive_low[2]), 32'd1);
  endtask

  initial begin
    build_table();
    reset_and_check();
    run_mux_table();
    run_pps_stretch();
    if (timeouts == 0) begin
      run_i2c();
    end
    $display("Checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/board_io_chk.sv ====
// Stretch length check holds for isolated PPS pulses only; bound into board_io_top below
`default_nettype none

module board_io_chk (
  input logic                         hif_clk,
  input logic                         hif_rst,
  input logic                         i_pps,
  input logic                         i_stretch,        // Stretcher level inside the DUT
  input board_pad_pkg::i2c_line_vec_t i_scl_en,
  input board_pad_pkg::i2c_line_vec_t i_sda_en,
  input board_pad_pkg::i2c_line_vec_t i_scl_drive_low,
  input board_pad_pkg::i2c_line_vec_t i_sda_drive_low,
  input board_pad_pkg::gpio_vec_t     i_gpio,
  input board_pad_pkg::cam_gpio_vec_t i_cam_gpio
);
  timeunit 1ns;
  timeprecision 100ps;

  // ------------------------------
  // PPS stretch
  // ------------------------------

  // Rise is sampled one edge after the pulse, the fall nine edges later
  stretch_len_a : assert property (@(posedge hif_clk) disable iff (hif_rst)
    $rose(i_stretch) |-> ##9 $fell(i_stretch))
    else $error("PPS stretch did not last 9 cycles");

  stretch_cause_a : assert property (@(posedge hif_clk) disable iff (hif_rst)
    $rose(i_stretch) |-> $past(i_pps))
    else $error("PPS stretch rose with no pulse in the previous cycle");

  // ------------------------------
  // Pads and GPIO
  // ------------------------------

  drive_low_a : assert property (@(posedge hif_clk)
    (i_scl_drive_low == ~i_scl_en) && (i_sda_drive_low == ~i_sda_en))
    else $error("I2C drive-low differs from the inverted enable");

  gpio_reset_a : assert property (@(posedge hif_clk)
    hif_rst |=> (i_gpio == '0) && (i_cam_gpio == '0))
    else $error("GPIO outputs not cleared by reset");

endmodule

bind board_io_top board_io_chk chk0 (
  .hif_clk         ( hif_clk                  ),
  .hif_rst         ( hif_rst                  ),
  .i_pps           ( i_pps                    ),
  .i_stretch       ( u_status_gen.pps_stretch ),
  .i_scl_en        ( i_scl_en                 ),
  .i_sda_en        ( i_sda_en                 ),
  .i_scl_drive_low ( o_scl_drive_low          ),
  .i_sda_drive_low ( o_sda_drive_low          ),
  .i_gpio          ( o_gpio                   ),
  .i_cam_gpio      ( o_cam_gpio               )
);

`default_nettype wire

// ==== verilog/board_io_top.sv ====
// Single hif_clk domain with synchronous reset; I2C pads are split into pin level and drive-low
`default_nettype none

module board_io_top (
  input  logic                           hif_clk,
  input  logic                           hif_rst,
  // Status sources
  input  logic                           i_pps,
  input  logic                           i_synth_locked,
  input  logic                           i_sensor_pll_locked,
  input  logic                           i_vsync,
  // GPIO
  input  board_status_pkg::gpio_mux_en_t i_mux_en,
  input  board_pad_pkg::gpio_vec_t       i_gpio_out,
  input  board_pad_pkg::cam_gpio_vec_t   i_cam_gpio_out,
  output board_pad_pkg::gpio_vec_t       o_gpio,
  output board_pad_pkg::cam_gpio_vec_t   o_cam_gpio,
  // I2C pads
  input  board_pad_pkg::i2c_line_vec_t   i_scl_pad,
  input  board_pad_pkg::i2c_line_vec_t   i_sda_pad,
  input  board_pad_pkg::i2c_line_vec_t   i_scl_en,
  input  board_pad_pkg::i2c_line_vec_t   i_sda_en,
  output board_pad_pkg::i2c_line_vec_t   o_scl_drive_low,
  output board_pad_pkg::i2c_line_vec_t   o_sda_drive_low,
  output board_pad_pkg::i2c_line_vec_t   o_scl,
  output board_pad_pkg::i2c_line_vec_t   o_sda
);

  // ------------------------------
  // Status to GPIO
  // ------------------------------

  debug_status_if u_status_if ();

  board_status_gen u_status_gen (
    .hif_clk             ( hif_clk                  ),
    .hif_rst             ( hif_rst                  ),
    .i_pps               ( i_pps                    ),
    .i_synth_locked      ( i_synth_locked           ),
    .i_sensor_pll_locked ( i_sensor_pll_locked      ),
    .i_vsync             ( i_vsync                  ),
    .status              ( u_status_if.producer     )
  );

  gpio_debug_mux u_gpio_mux (
    .hif_clk             ( hif_clk                  ),
    .hif_rst             ( hif_rst                  ),
    .status              ( u_status_if.consumer     ),
    .i_mux_en            ( i_mux_en                 ),
    .i_gpio_out          ( i_gpio_out               ),
    .i_cam_gpio_out      ( i_cam_gpio_out           ),
    .o_gpio              ( o_gpio                   ),  // PPS pin is o_gpio[15]
    .o_cam_gpio          ( o_cam_gpio               )
  );

  // ------------------------------
  // I2C pads
  // ------------------------------

  i2c_pad_ctrl u_i2c_pad (
    .hif_clk             ( hif_clk                  ),
    .hif_rst             ( hif_rst                  ),
    .i_scl_pad           ( i_scl_pad                ),
    .i_sda_pad           ( i_sda_pad                ),
    .i_scl_en            ( i_scl_en                 ),
    .i_sda_en            ( i_sda_en                 ),
    .o_scl_drive_low     ( o_scl_drive_low          ),
    .o_sda_drive_low     ( o_sda_drive_low          ),
    .o_scl               ( o_scl                    ),
    .o_sda               ( o_sda                    )
  );

endmodule

`default_nettype wire

// ==== verilog/gpio_debug_mux.sv ====
// Outputs lag their inputs by one hif_clk cycle and the reserved enable bit has no effect
`default_nettype none

module gpio_debug_mux (
  input  logic                         hif_clk,
  input  logic                         hif_rst,
  debug_status_if.consumer             status,
  input  board_status_pkg::gpio_mux_en_t i_mux_en,
  input  board_pad_pkg::gpio_vec_t     i_gpio_out,      // User values
  input  board_pad_pkg::cam_gpio_vec_t i_cam_gpio_out,
  output board_pad_pkg::gpio_vec_t     o_gpio,
  output board_pad_pkg::cam_gpio_vec_t o_cam_gpio
);

  import board_pad_pkg::*;

  // Status pins on the main header
  localparam int GPIO_PPS_PIN   = 15;
  localparam int GPIO_VSYNC_PIN = 14;
  localparam int GPIO_SYNTH_PIN = 13;
  localparam int GPIO_PLL_PIN   = 12;

  // Camera vsync pins, indexed by cam_vsync_en bit
  localparam int CAM_VSYNC_PIN [4] = '{3, 6, 7, 8};

  gpio_vec_t     gpio_nxt;
  cam_gpio_vec_t cam_gpio_nxt;

  // ------------------------------
  // Override select
  // ------------------------------

  always_comb begin
    gpio_nxt     = i_gpio_out;      // Default is the user value
    cam_gpio_nxt = i_cam_gpio_out;
    if (i_mux_en.pps_en) gpio_nxt[GPIO_PPS_PIN] = status.pps_stretch;
    if (i_mux_en.vsync_en) gpio_nxt[GPIO_VSYNC_PIN] = status.vsync;
    if (i_mux_en.lock_en) begin     // One enable for both lock pins
      gpio_nxt[GPIO_SYNTH_PIN] = status.synth_lock;
      gpio_nxt[GPIO_PLL_PIN]   = status.sensor_pll_lock;
    end
    for (int k = 0; k < 4; k++) begin
      if (i_mux_en.cam_vsync_en[k]) cam_gpio_nxt[CAM_VSYNC_PIN[k]] = status.vsync;
    end
  end

  // ------------------------------
  // Output register
  // ------------------------------

  always_ff @(posedge hif_clk) begin
    if (hif_rst) begin
      o_gpio     <= '0;
      o_cam_gpio <= '0;
    end else begin
      o_gpio     <= gpio_nxt;
      o_cam_gpio <= cam_gpio_nxt;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/i2c_pad_ctrl.sv ====
// Pads need an external open-drain buffer that pulls low on drive_low and floats high otherwise
`default_nettype none

`include "board_defs.svh"

module i2c_pad_ctrl (
  input  logic                         hif_clk,
  input  logic                         hif_rst,
  input  board_pad_pkg::i2c_line_vec_t i_scl_pad,        // Pin levels
  input  board_pad_pkg::i2c_line_vec_t i_sda_pad,
  input  board_pad_pkg::i2c_line_vec_t i_scl_en,         // Low pulls the line down
  input  board_pad_pkg::i2c_line_vec_t i_sda_en,
  output board_pad_pkg::i2c_line_vec_t o_scl_drive_low,
  output board_pad_pkg::i2c_line_vec_t o_sda_drive_low,
  output board_pad_pkg::i2c_line_vec_t o_scl,            // Filtered readback
  output board_pad_pkg::i2c_line_vec_t o_sda
);

  import board_pad_pkg::*;

  i2c_pair_vec_t pad_raw;   // {SDA, SCL} as seen on the pins
  i2c_pair_vec_t pad_filt;
  i2c_line_vec_t scl_filt;
  i2c_line_vec_t sda_filt;

  // ------------------------------
  // Line filtering
  // ------------------------------

  assign pad_raw = {i_sda_pad, i_scl_pad};

  // Bus idles high, so the filter resets to 1
  glitch_filter #(
    .WIDTH       ( 2*`I2C_PORTS  ),
    .DEPTH       ( `GLITCH_DEPTH ),
    .RESET_VALUE ( 1'b1          )
  ) u_line_filter (
    .hif_clk     ( hif_clk       ),
    .hif_rst     ( hif_rst       ),
    .i_din       ( pad_raw       ),
    .o_dout      ( pad_filt      )
  );

  assign scl_filt = pad_filt[`I2C_PORTS-1:0];
  assign sda_filt = pad_filt[2*`I2C_PORTS-1:`I2C_PORTS];

  // ------------------------------
  // Drive and readback
  // ------------------------------

  assign o_scl_drive_low = ~i_scl_en;  // Open drain
  assign o_sda_drive_low = ~i_sda_en;

  assign o_scl = scl_filt & i_scl_en;  // Disabled port reads 0
  assign o_sda = sda_filt & i_sda_en;

endmodule

`default_nettype wire

// ==== verilog/board_status_gen.sv ====
// i_pps must already be a hif_clk pulse; the lock and vsync inputs may be asynchronous
`default_nettype none

`include "board_defs.svh"

module board_status_gen (
  input  logic             hif_clk,
  input  logic             hif_rst,
  input  logic             i_pps,                // One-cycle pulse
  input  logic             i_synth_locked,       // Async level
  input  logic             i_sensor_pll_locked,  // Async level
  input  logic             i_vsync,              // Async strobe
  debug_status_if.producer status
);

  import board_status_pkg::*;

  // ------------------------------
  // Input synchronizers
  // ------------------------------

  sync_chain_t synth_lock_sync;
  sync_chain_t pll_lock_sync;
  sync_chain_t vsync_sync;

  // Shift toward the MSB, output after SYNC_STAGES edges
  always_ff @(posedge hif_clk) begin
    if (hif_rst) begin
      synth_lock_sync <= '0;
      pll_lock_sync   <= '0;
      vsync_sync      <= '0;
    end else begin
      synth_lock_sync <= {synth_lock_sync[`SYNC_STAGES-2:0], i_synth_locked};
      pll_lock_sync   <= {pll_lock_sync[`SYNC_STAGES-2:0], i_sensor_pll_locked};
      vsync_sync      <= {vsync_sync[`SYNC_STAGES-2:0], i_vsync};
    end
  end

  assign status.synth_lock      = synth_lock_sync[`SYNC_STAGES-1];
  assign status.sensor_pll_lock = pll_lock_sync[`SYNC_STAGES-1];
  assign status.vsync           = vsync_sync[`SYNC_STAGES-1];

  // ------------------------------
  // PPS stretch
  // ------------------------------

  pps_cnt_t pps_cnt;      // Cycles since the stretch began
  logic     pps_stretch;
  logic     pps_done;

  assign pps_done = pps_cnt[`PPS_TIMER_BIT];  // Set after 2**PPS_TIMER_BIT counts

  // Isolated pulse holds the level for 2**PPS_TIMER_BIT+1 cycles
  always_ff @(posedge hif_clk) begin
    if (hif_rst) begin
      pps_stretch <= 1'b0;
      pps_cnt     <= '0;
    end else if (i_pps) begin
      pps_stretch <= 1'b1;                // Counter keeps its place on a repeat pulse
    end else if (pps_done) begin
      pps_stretch <= 1'b0;
      pps_cnt     <= '0;
    end else if (pps_stretch) begin
      pps_cnt     <= pps_cnt + 1'b1;
    end
  end

  assign status.pps_stretch = pps_stretch;

endmodule

`default_nettype wire

// ==== verilog/glitch_filter.sv ====
// Every bit is treated as asynchronous; a change shows after SYNC_STAGES plus DEPTH stable cycles
`default_nettype none

`include "board_defs.svh"

module glitch_filter #(
  parameter int   WIDTH       = 1,
  parameter int   DEPTH       = 8,     // Consecutive differing samples needed
  parameter logic RESET_VALUE = 1'b1   // Idle level of every bit
) (
  input  logic             hif_clk,
  input  logic             hif_rst,
  input  logic [WIDTH-1:0] i_din,
  output logic [WIDTH-1:0] o_dout
);

  localparam int               CNT_W    = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEPTH - 1);

  logic [WIDTH-1:0] sync_q [`SYNC_STAGES];  // Stage 0 samples the pins
  logic [WIDTH-1:0] sample;                 // Synchronized value
  logic [CNT_W-1:0] stab_cnt [WIDTH];       // Run length of a differing value

  assign sample = sync_q[`SYNC_STAGES-1];

  // ------------------------------
  // Synchronizer
  // ------------------------------

  always_ff @(posedge hif_clk) begin
    if (hif_rst) begin
      for (int s = 0; s < `SYNC_STAGES; s++) begin
        sync_q[s] <= {WIDTH{RESET_VALUE}};
      end
    end else begin
      sync_q[0] <= i_din;
      for (int s = 1; s < `SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
    end
  end

  // ------------------------------
  // Stability filter
  // ------------------------------

  always_ff @(posedge hif_clk) begin
    if (hif_rst) begin
      o_dout <= {WIDTH{RESET_VALUE}};
      for (int b = 0; b < WIDTH; b++) begin
        stab_cnt[b] <= '0;
      end
    end else begin
      for (int b = 0; b < WIDTH; b++) begin
        if (sample[b] == o_dout[b]) begin
          stab_cnt[b] <= '0;                   // Glitch over, start again
        end else if (stab_cnt[b] == CNT_LAST) begin
          stab_cnt[b] <= '0;
          o_dout[b]   <= sample[b];            // DEPTH samples in a row
        end else begin
          stab_cnt[b] <= stab_cnt[b] + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/debug_status_if.sv ====
// Level signals only with no handshake; vsync is a strobe and the consumer sees it unchanged
`default_nettype none

interface debug_status_if;

  logic pps_stretch;      // Stretched PPS level
  logic synth_lock;       // Clock synthesizer lock, synchronized
  logic sensor_pll_lock;  // Sensor PLL lock, synchronized
  logic vsync;            // Vsync strobe, synchronized

  // Status generator side
  modport producer (
    output pps_stretch,
    output synth_lock,
    output sensor_pll_lock,
    output vsync
  );

  // Debug mux side
  modport consumer (
    input pps_stretch,
    input synth_lock,
    input sensor_pll_lock,
    input vsync
  );

endinterface

`default_nettype wire

// ==== verilog/board_pad_pkg.sv ====
// Pad vector types sized from board_defs.svh; one I2C bit per port with port 0 the control bus
`default_nettype none

`include "board_defs.svh"

package board_pad_pkg;

  // ------------------------------
  // GPIO banks
  // ------------------------------

  typedef logic [`GPIO_WIDTH-1:0]     gpio_vec_t;      // Main header
  typedef logic [`CAM_GPIO_WIDTH-1:0] cam_gpio_vec_t;  // Camera connector

  // ------------------------------
  // I2C lines
  // ------------------------------

  // Bit 0 is the control bus, bits 1..3 the cameras
  typedef logic [`I2C_PORTS-1:0] i2c_line_vec_t;

  // SCL set in the low half, SDA set in the high half
  typedef logic [2*`I2C_PORTS-1:0] i2c_pair_vec_t;

endpackage

`default_nettype wire

// ==== verilog/board_status_pkg.sv ====
// Status path types sized from board_defs.svh, so the header must be on the include path
`default_nettype none

`include "board_defs.svh"

package board_status_pkg;

  // ------------------------------
  // Debug mux enables
  // ------------------------------

  // Packed MSB first, so cam_vsync_en sits in bits 7:4
  typedef struct packed {
    logic [3:0] cam_vsync_en;  // Vsync onto camera GPIO 3, 6, 7, 8 (bit 4 first)
    logic       reserved;      // Ignored by the mux
    logic       lock_en;       // Synth lock to GPIO 13 and sensor PLL lock to GPIO 12
    logic       vsync_en;      // Vsync to GPIO 14
    logic       pps_en;        // PPS stretch to GPIO 15
  } gpio_mux_en_t;

  // ------------------------------
  // Status conditioning
  // ------------------------------

  // Stretch counter, top bit ends the stretch
  typedef logic [`PPS_TIMER_BIT:0] pps_cnt_t;

  // One synchronizer chain, bit 0 samples the pin
  typedef logic [`SYNC_STAGES-1:0] sync_chain_t;

endpackage

`default_nettype wire

// ==== include/board_defs.svh ====
// Widths and depths are fixed at elaboration, and SYNC_STAGES must be 2 or more
`ifndef BOARD_DEFS_SVH
`define BOARD_DEFS_SVH

// ------------------------------
// I2C lines
// ------------------------------

`define I2C_PORTS       4    // Control port plus three camera ports
`define GLITCH_DEPTH    8    // Stable samples before a line change is taken

// ------------------------------
// Status conditioning
// ------------------------------

// Flops per synchronizer chain
`define SYNC_STAGES     2

// Stretch ends one edge after this counter bit sets
// 3 gives 2**3+1 cycles of PPS level
`define PPS_TIMER_BIT   3

// ------------------------------
// GPIO banks
// ------------------------------

`define GPIO_WIDTH      16   // Main header GPIO
`define CAM_GPIO_WIDTH  15   // Camera connector GPIO

// Top four GPIO bits carry status
// Camera bits 3, 6, 7 and 8 carry vsync

`endif
